// File: hdl/cu_pkg.sv
// compute unit widths, record stride, address helper, payload structs and FSM state enums
`default_nettype none

package cu_pkg;

	////////////////////////////////////////
	// widths and record layout
	////////////////////////////////////////

	localparam int VERTEX_ID_BITS  = 16;
	localparam int ADDR_BITS       = 32;
	localparam int DEGREE_BITS     = 16;
	localparam int EDGE_COUNT_BITS = 32;
	// one word per vertex, both in the degree array and in the result array
	localparam int VERTEX_STRIDE   = 4;

	typedef logic [VERTEX_ID_BITS-1:0]  vertex_id_t;
	typedef logic [ADDR_BITS-1:0]       addr_t;
	typedef logic [DEGREE_BITS-1:0]     degree_t;
	typedef logic [EDGE_COUNT_BITS-1:0] edge_count_t;

	////////////////////////////////////////
	// payloads
	////////////////////////////////////////

	typedef struct packed {
		vertex_id_t num_vertices;
		addr_t      vertex_base;
		addr_t      result_base;
	} cu_config_t;

	typedef struct packed {
		vertex_id_t vertex_id;
		addr_t      addr;
	} rd_cmd_t;

	typedef struct packed {
		vertex_id_t vertex_id;
		degree_t    degree;
	} rd_rsp_t;

	typedef struct packed {
		vertex_id_t vertex_id;
		degree_t    degree;
	} vertex_job_t;

	typedef struct packed {
		addr_t      addr;
		vertex_id_t vertex_id;
		degree_t    degree;
	} wr_cmd_t;

	typedef struct packed {
		vertex_id_t  vertices_done;
		edge_count_t edges_done;
	} cu_return_t;

	////////////////////////////////////////
	// state machines
	////////////////////////////////////////

	typedef enum logic [2:0] {
		SRC_IDLE,
		SRC_RD_REQ,
		SRC_RD_REL,
		SRC_RSP_WAIT,
		SRC_RSP_PUSH,
		SRC_RSP_REL
	} source_state_t;

	typedef enum logic [1:0] {
		WR_IDLE,
		WR_REQ,
		WR_REL
	} write_state_t;

	// address of the record that belongs to one vertex
	function automatic addr_t record_addr(input addr_t base, input vertex_id_t id);
		return base + addr_t'(id) * addr_t'(VERTEX_STRIDE);
	endfunction

endpackage

`default_nettype wire

// File: hdl/vertex_job_source.sv
// vertex job source, reads degree records in id order and pushes nonzero-degree jobs
`default_nettype none
`timescale 1ns/1ps

module vertex_job_source
	import cu_pkg::*;
(
	input  wire              clock,
	input  wire              rstn,
	input  wire              start,
	input  wire cu_config_t  cfg,
	input  wire              rd_ack,
	input  wire              rsp_req,
	input  wire rd_rsp_t     rd_rsp,
	input  wire              push_ready,
	output logic             rd_req,
	output rd_cmd_t          rd_cmd,
	output logic             rsp_ack,
	output logic             push_valid,
	output vertex_job_t      push_job,
	output vertex_id_t       filtered_count
);

	source_state_t state;
	vertex_id_t    next_id;
	vertex_id_t    following_id;
	vertex_id_t    issue_id;
	logic          issue_read;
	logic          take_rsp;

	assign following_id = next_id + vertex_id_t'(1);

	// a new read starts from idle, or right when the previous response is released
	assign issue_read = (state == SRC_IDLE && start && next_id < cfg.num_vertices) ||
		(state == SRC_RSP_REL && !rsp_req && following_id < cfg.num_vertices);
	assign issue_id   = (state == SRC_IDLE) ? next_id : following_id;
	assign take_rsp   = (state == SRC_RSP_WAIT) && rsp_req;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state          <= SRC_IDLE;
			next_id        <= '0;
			rd_req         <= 1'b0;
			rsp_ack        <= 1'b0;
			push_valid     <= 1'b0;
			filtered_count <= '0;
		end else begin
			case (state)
				SRC_IDLE: begin
					if (issue_read) begin
						rd_req <= 1'b1;
						state  <= SRC_RD_REQ;
					end
				end
				SRC_RD_REQ: begin
					if (rd_ack) begin
						rd_req <= 1'b0;
						state  <= SRC_RD_REL;
					end
				end
				SRC_RD_REL: begin
					if (!rd_ack) begin
						state <= SRC_RSP_WAIT;
					end
				end
				SRC_RSP_WAIT: begin
					if (take_rsp) begin
						// zero degree, nothing to write for this vertex
						if (rd_rsp.degree == '0) begin
							filtered_count <= filtered_count + vertex_id_t'(1);
							rsp_ack        <= 1'b1;
							state          <= SRC_RSP_REL;
						end else begin
							push_valid <= 1'b1;
							state      <= SRC_RSP_PUSH;
						end
					end
				end
				SRC_RSP_PUSH: begin
					// a full queue holds the response unacknowledged
					if (push_ready) begin
						push_valid <= 1'b0;
						rsp_ack    <= 1'b1;
						state      <= SRC_RSP_REL;
					end
				end
				SRC_RSP_REL: begin
					if (!rsp_req) begin
						rsp_ack <= 1'b0;
						next_id <= following_id;
						if (issue_read) begin
							rd_req <= 1'b1;
							state  <= SRC_RD_REQ;
						end else begin
							state <= SRC_IDLE;
						end
					end
				end
				default: state <= SRC_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (issue_read) begin
			rd_cmd <= '{vertex_id: issue_id, addr: record_addr(cfg.vertex_base, issue_id)};
		end
		if (take_rsp) begin
			push_job <= '{vertex_id: rd_rsp.vertex_id, degree: rd_rsp.degree};
		end
	end

	// read request is held until memory acknowledges it
	assert property (@(posedge clock) disable iff (!rstn) rd_req && !rd_ack |=> rd_req)
		else $error("rd_req dropped before rd_ack");

endmodule

`default_nettype wire

// File: hdl/vertex_job_queue.sv
// vertex job FIFO between the job source and the write unit
`default_nettype none
`timescale 1ns/1ps

module vertex_job_queue
	import cu_pkg::*;
#(
	parameter int QUEUE_DEPTH = 4
) (
	input  wire              clock,
	input  wire              rstn,
	input  wire              push_valid,
	input  wire vertex_job_t push_job,
	input  wire              pop_ready,
	output logic             push_ready,
	output logic             pop_valid,
	output vertex_job_t      pop_job
);

	localparam int PTR_BITS   = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
	localparam int COUNT_BITS = $clog2(QUEUE_DEPTH + 1);

	vertex_job_t           mem [QUEUE_DEPTH];
	logic [PTR_BITS-1:0]   wr_ptr;
	logic [PTR_BITS-1:0]   rd_ptr;
	logic [COUNT_BITS-1:0] count;
	logic                  do_push;
	logic                  do_pop;

	assign push_ready = (count != COUNT_BITS'(QUEUE_DEPTH));
	assign pop_valid  = (count != '0);
	assign pop_job    = mem[rd_ptr];
	assign do_push    = push_valid && push_ready;
	assign do_pop     = pop_valid && pop_ready;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == PTR_BITS'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == PTR_BITS'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			// occupancy moves only when exactly one side fires
			if (do_push && !do_pop) begin
				count <= count + 1'b1;
			end else if (do_pop && !do_push) begin
				count <= count - 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= push_job;
		end
	end

	// while full, the offered job stays offered and unchanged
	assert property (@(posedge clock) disable iff (!rstn)
		!push_ready && push_valid |=> push_valid && $stable(push_job))
		else $error("job changed or withdrawn while queue full");

	// leaving empty, the head is the job that was just pushed
	assert property (@(posedge clock) disable iff (!rstn)
		!pop_valid |=> !pop_valid || pop_job == $past(push_job))
		else $error("queue head differs from pushed job");

endmodule

`default_nettype wire

// File: hdl/vertex_write_unit.sv
// vertex write unit, pops jobs, writes result records and counts vertices and edges done
`default_nettype none
`timescale 1ns/1ps

module vertex_write_unit
	import cu_pkg::*;
(
	input  wire              clock,
	input  wire              rstn,
	input  wire              start,
	input  wire addr_t       result_base,
	input  wire              pop_valid,
	input  wire vertex_job_t pop_job,
	input  wire              wr_ack,
	output logic             pop_ready,
	output logic             wr_req,
	output wr_cmd_t          wr_cmd,
	output vertex_id_t       vertices_done,
	output edge_count_t      edges_done
);

	write_state_t state;
	logic         take_job;

	// one write in flight, so a slow wr_ack holds the queue
	assign pop_ready = start && (state == WR_IDLE);
	assign take_job  = pop_valid && pop_ready;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state         <= WR_IDLE;
			wr_req        <= 1'b0;
			vertices_done <= '0;
			edges_done    <= '0;
		end else begin
			case (state)
				WR_IDLE: begin
					if (take_job) begin
						wr_req <= 1'b1;
						state  <= WR_REQ;
					end
				end
				WR_REQ: begin
					if (wr_ack) begin
						wr_req <= 1'b0;
						state  <= WR_REL;
					end
				end
				WR_REL: begin
					// counted once the write handshake is fully released
					if (!wr_ack) begin
						vertices_done <= vertices_done + vertex_id_t'(1);
						edges_done    <= edges_done + edge_count_t'(wr_cmd.degree);
						state         <= WR_IDLE;
					end
				end
				default: state <= WR_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (take_job) begin
			wr_cmd <= '{
				addr:      record_addr(result_base, pop_job.vertex_id),
				vertex_id: pop_job.vertex_id,
				degree:    pop_job.degree
			};
		end
	end

	// write payload holds while the request is up
	assert property (@(posedge clock) disable iff (!rstn) wr_req |=> !wr_req || $stable(wr_cmd))
		else $error("wr_cmd changed while wr_req high");

endmodule

`default_nettype wire

// File: hdl/cu_control.sv
// compute unit control top, config capture, start, done detection and job pipeline
`default_nettype none
`timescale 1ns/1ps

module cu_control
	import cu_pkg::*;
#(
	parameter int QUEUE_DEPTH = 4
) (
	input  wire              clock,
	input  wire              rstn,
	input  wire              enable,
	input  wire cu_config_t  cfg_in,
	input  wire              rd_ack,
	input  wire              rsp_req,
	input  wire rd_rsp_t     rd_rsp,
	input  wire              wr_ack,
	output logic             rd_req,
	output rd_cmd_t          rd_cmd,
	output logic             rsp_ack,
	output logic             wr_req,
	output wr_cmd_t          wr_cmd,
	output logic             done,
	output cu_return_t       cu_return
);

	cu_config_t              cfg_q;
	logic                    cfg_ready;
	logic                    start;
	logic                    push_valid;
	logic                    push_ready;
	vertex_job_t             push_job;
	logic                    pop_valid;
	logic                    pop_ready;
	vertex_job_t             pop_job;
	vertex_id_t              filtered_count;
	vertex_id_t              vertices_done;
	edge_count_t             edges_done;
	logic [VERTEX_ID_BITS:0] handled_count;

	////////////////////////////////////////
	// configuration and start
	////////////////////////////////////////

	// a zero field leaves the captured value alone
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cfg_q <= '0;
		end else if (enable) begin
			if (cfg_in.num_vertices != '0) begin
				cfg_q.num_vertices <= cfg_in.num_vertices;
			end
			if (cfg_in.vertex_base != '0) begin
				cfg_q.vertex_base <= cfg_in.vertex_base;
			end
			if (cfg_in.result_base != '0) begin
				cfg_q.result_base <= cfg_in.result_base;
			end
		end
	end

	assign cfg_ready = (cfg_q.num_vertices != '0) && (cfg_q.vertex_base != '0) &&
		(cfg_q.result_base != '0);

	// captured fields never return to zero, so start stays set once raised
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			start <= 1'b0;
		end else begin
			start <= cfg_ready;
		end
	end

	////////////////////////////////////////
	// done and return value
	////////////////////////////////////////

	assign handled_count = {1'b0, vertices_done} + {1'b0, filtered_count};

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			done      <= 1'b0;
			cu_return <= '0;
		end else begin
			cu_return <= '{vertices_done: vertices_done, edges_done: edges_done};
			if (start && handled_count == {1'b0, cfg_q.num_vertices}) begin
				done <= 1'b1;
			end
		end
	end

	// all vertices accounted for means no handshake is still open
	assert property (@(posedge clock) disable iff (!rstn) done |-> !rd_req && !wr_req)
		else $error("done raised with a request outstanding");

	////////////////////////////////////////
	// job pipeline
	////////////////////////////////////////

	vertex_job_source source_i (
		.clock          (clock),
		.rstn           (rstn),
		.start          (start),
		.cfg            (cfg_q),
		.rd_ack         (rd_ack),
		.rsp_req        (rsp_req),
		.rd_rsp         (rd_rsp),
		.push_ready     (push_ready),
		.rd_req         (rd_req),
		.rd_cmd         (rd_cmd),
		.rsp_ack        (rsp_ack),
		.push_valid     (push_valid),
		.push_job       (push_job),
		.filtered_count (filtered_count)
	);

	vertex_job_queue #(
		.QUEUE_DEPTH (QUEUE_DEPTH)
	) queue_i (
		.clock      (clock),
		.rstn       (rstn),
		.push_valid (push_valid),
		.push_job   (push_job),
		.pop_ready  (pop_ready),
		.push_ready (push_ready),
		.pop_valid  (pop_valid),
		.pop_job    (pop_job)
	);

	vertex_write_unit write_i (
		.clock         (clock),
		.rstn          (rstn),
		.start         (start),
		.result_base   (cfg_q.result_base),
		.pop_valid     (pop_valid),
		.pop_job       (pop_job),
		.wr_ack        (wr_ack),
		.pop_ready     (pop_ready),
		.wr_req        (wr_req),
		.wr_cmd        (wr_cmd),
		.vertices_done (vertices_done),
		.edges_done    (edges_done)
	);

endmodule

`default_nettype wire

// File: dv/cu_control_tb.sv
// cu_control testbench with clock, reset, memory model, write acknowledger and checking assertions
`default_nettype none
`timescale 1ns/1ps

module cu_control_tb
	import cu_pkg::*;
;

	localparam int    QUEUE_DEPTH  = 4;
	localparam int    NUM_VERTICES = 40;
	localparam addr_t VERTEX_BASE  = 32'h0001_0000;
	localparam addr_t RESULT_BASE  = 32'h0008_0000;
	localparam int    WAIT_LIMIT   = 2000;
	localparam int    DONE_LIMIT   = 40000;

	typedef enum {WATCH_RD_REQ, WATCH_RSP_ACK, WATCH_WR_REQ, WATCH_DONE} watch_t;

	logic        clock = 1'b0;
	logic        rstn;
	logic        enable;
	cu_config_t  cfg_in;
	logic        rd_ack;
	logic        rsp_req;
	rd_rsp_t     rd_rsp;
	logic        wr_ack;
	logic        rd_req;
	rd_cmd_t     rd_cmd;
	logic        rsp_ack;
	logic        wr_req;
	wr_cmd_t     wr_cmd;
	logic        done;
	cu_return_t  cu_return;

	degree_t     degree_table [NUM_VERTICES];
	vertex_id_t  exp_vertices;
	edge_count_t exp_edges;
	vertex_id_t  exp_rd_id;
	vertex_id_t  last_wr_id;
	logic        wrote_any;
	vertex_id_t  rd_id;
	logic [31:0] rd_rng;
	logic [31:0] wr_rng;

	always #2 clock = ~clock;

	cu_control #(
		.QUEUE_DEPTH (QUEUE_DEPTH)
	) cu_control_i (
		.clock     (clock),
		.rstn      (rstn),
		.enable    (enable),
		.cfg_in    (cfg_in),
		.rd_ack    (rd_ack),
		.rsp_req   (rsp_req),
		.rd_rsp    (rd_rsp),
		.wr_ack    (wr_ack),
		.rd_req    (rd_req),
		.rd_cmd    (rd_cmd),
		.rsp_ack   (rsp_ack),
		.wr_req    (wr_req),
		.wr_cmd    (wr_cmd),
		.done      (done),
		.cu_return (cu_return)
	);

	////////////////////////////////////////
	// helpers
	////////////////////////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	task automatic stop_run();
		$display("test failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic value_mismatch(input string test, input longint unsigned expected,
		input longint unsigned actual);
		$display("[FAIL] %s expected 0x%0h actual 0x%0h", test, expected, actual);
		stop_run();
	endtask

	task automatic protocol_break(input string what);
		$display("protocol error, %s", what);
		stop_run();
	endtask

	function automatic logic watched_level(input watch_t sel);
		case (sel)
			WATCH_RD_REQ:  return rd_req;
			WATCH_RSP_ACK: return rsp_ack;
			WATCH_WR_REQ:  return wr_req;
			default:       return done;
		endcase
	endfunction

	// polls on the falling edge, where DUT outputs are settled
	task automatic wait_for(input watch_t sel, input logic level, input int limit);
		int cycles;
		cycles = 0;
		while (watched_level(sel) !== level && cycles < limit) begin
			@(negedge clock);
			cycles++;
		end
		if (watched_level(sel) !== level) begin
			$display("timed out waiting for %s to become %0b", sel.name(), level);
			stop_run();
		end
	endtask

	task automatic pause(input int cycles);
		repeat (cycles) @(negedge clock);
	endtask

	task automatic fill_degree_table();
		logic [31:0] rng;
		rng          = 32'd1;
		exp_vertices = '0;
		exp_edges    = '0;
		for (int i = 0; i < NUM_VERTICES; i++) begin
			rng = xorshift32(rng);
			// about one vertex in four has no edges
			if (rng[1:0] == 2'b00) begin
				degree_table[i] = '0;
			end else begin
				degree_table[i] = degree_t'(rng[11:4]) + degree_t'(1);
				exp_vertices    = exp_vertices + vertex_id_t'(1);
				exp_edges       = exp_edges + edge_count_t'(degree_table[i]);
			end
		end
		rd_rng = xorshift32(rng);
		wr_rng = xorshift32(rd_rng);
	endtask

	////////////////////////////////////////
	// stimulus
	////////////////////////////////////////

	initial begin
		rstn   = 1'b0;
		enable = 1'b0;
		cfg_in = '0;
		fill_degree_table();
		pause(8);
		rstn = 1'b1;
		pause(1);
		enable = 1'b1;
		cfg_in = '{num_vertices: vertex_id_t'(NUM_VERTICES), vertex_base: VERTEX_BASE,
			result_base: RESULT_BASE};
		pause(1);
		// zero fields keep the captured configuration
		cfg_in = '0;
		pause(3);
		// changed values while disabled must be ignored
		enable = 1'b0;
		cfg_in = '{num_vertices: vertex_id_t'(NUM_VERTICES + 7),
			vertex_base: VERTEX_BASE + 32'h100, result_base: RESULT_BASE + 32'h200};
		wait_for(WATCH_DONE, 1'b1, DONE_LIMIT);
		pause(4);
		$display("test passed");
		$finish;
	end

	// memory model, one read at a time with random latency
	initial begin
		rd_ack  = 1'b0;
		rsp_req = 1'b0;
		rd_rsp  = '0;
		forever begin
			wait_for(WATCH_RD_REQ, 1'b1, WAIT_LIMIT);
			rd_rng = xorshift32(rd_rng);
			pause(int'(rd_rng[1:0]));
			rd_id  = rd_cmd.vertex_id;
			rd_ack = 1'b1;
			wait_for(WATCH_RD_REQ, 1'b0, WAIT_LIMIT);
			rd_ack = 1'b0;
			pause(int'(rd_rng[6:4]));
			rd_rsp  = '{vertex_id: rd_id, degree: degree_table[rd_id]};
			rsp_req = 1'b1;
			wait_for(WATCH_RSP_ACK, 1'b1, WAIT_LIMIT);
			rsp_req = 1'b0;
			wait_for(WATCH_RSP_ACK, 1'b0, WAIT_LIMIT);
		end
	end

	// write acknowledger, long stalls now and then fill the queue
	initial begin
		wr_ack = 1'b0;
		forever begin
			wait_for(WATCH_WR_REQ, 1'b1, WAIT_LIMIT);
			wr_rng = xorshift32(wr_rng);
			if (wr_rng[2:0] == 3'b000) begin
				pause(40 + int'(wr_rng[8:4]));
			end else begin
				pause(int'(wr_rng[5:4]));
			end
			wr_ack = 1'b1;
			wait_for(WATCH_WR_REQ, 1'b0, WAIT_LIMIT);
			wr_ack = 1'b0;
		end
	end

	////////////////////////////////////////
	// checking
	////////////////////////////////////////

	// req and ack are both high at exactly one rising edge per handshake
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			exp_rd_id  <= '0;
			last_wr_id <= '0;
			wrote_any  <= 1'b0;
		end else begin
			if (rd_req && rd_ack) begin
				exp_rd_id <= exp_rd_id + vertex_id_t'(1);
			end
			if (wr_req && wr_ack) begin
				last_wr_id <= wr_cmd.vertex_id;
				wrote_any  <= 1'b1;
			end
		end
	end

	read_id: assert property (@(posedge clock) disable iff (!rstn)
		rd_req && rd_ack |-> rd_cmd.vertex_id == exp_rd_id)
		else value_mismatch("read_order id", $sampled(exp_rd_id), $sampled(rd_cmd.vertex_id));

	read_addr: assert property (@(posedge clock) disable iff (!rstn)
		rd_req && rd_ack |-> rd_cmd.addr == VERTEX_BASE + addr_t'(exp_rd_id) * VERTEX_STRIDE)
		else value_mismatch("read_order addr",
			VERTEX_BASE + addr_t'($sampled(exp_rd_id)) * VERTEX_STRIDE, $sampled(rd_cmd.addr));

	write_addr: assert property (@(posedge clock) disable iff (!rstn)
		wr_req && wr_ack |-> wr_cmd.addr == RESULT_BASE + addr_t'(wr_cmd.vertex_id) * VERTEX_STRIDE)
		else value_mismatch("write_content addr",
			RESULT_BASE + addr_t'($sampled(wr_cmd.vertex_id)) * VERTEX_STRIDE,
			$sampled(wr_cmd.addr));

	write_degree: assert property (@(posedge clock) disable iff (!rstn)
		wr_req && wr_ack |-> wr_cmd.degree == degree_table[wr_cmd.vertex_id])
		else value_mismatch("write_content degree", degree_table[$sampled(wr_cmd.vertex_id)],
			$sampled(wr_cmd.degree));

	write_nonzero: assert property (@(posedge clock) disable iff (!rstn)
		wr_req && wr_ack |-> wr_cmd.degree != '0)
		else protocol_break("a vertex with zero degree was written");

	write_order: assert property (@(posedge clock) disable iff (!rstn)
		wr_req && wr_ack && wrote_any |-> wr_cmd.vertex_id > last_wr_id)
		else begin
			$display("[FAIL] write_content expected id above %0d actual %0d",
				$sampled(last_wr_id), $sampled(wr_cmd.vertex_id));
			stop_run();
		end

	done_vertices: assert property (@(posedge clock) disable iff (!rstn)
		done |-> cu_return.vertices_done == exp_vertices)
		else value_mismatch("completion vertices_done", exp_vertices,
			$sampled(cu_return.vertices_done));

	done_edges: assert property (@(posedge clock) disable iff (!rstn)
		done |-> cu_return.edges_done == exp_edges)
		else value_mismatch("completion edges_done", exp_edges, $sampled(cu_return.edges_done));

	// four-phase rules on the three channels
	rd_release: assert property (@(posedge clock) disable iff (!rstn)
		$fell(rd_req) |-> rd_ack || $past(rd_ack))
		else protocol_break("rd_req fell before rd_ack rose");

	// the DUT answers the response channel, so its ack is what gets checked there
	rsp_release: assert property (@(posedge clock) disable iff (!rstn)
		$fell(rsp_ack) |-> !$past(rsp_req))
		else protocol_break("rsp_ack fell before rsp_req was released");

	wr_release: assert property (@(posedge clock) disable iff (!rstn)
		$fell(wr_req) |-> wr_ack || $past(wr_ack))
		else protocol_break("wr_req fell before wr_ack rose");

	rd_reopen: assert property (@(posedge clock) disable iff (!rstn)
		$rose(rd_req) |-> !$past(rd_ack))
		else protocol_break("rd_req rose while rd_ack was still high");

	wr_reopen: assert property (@(posedge clock) disable iff (!rstn)
		$rose(wr_req) |-> !$past(wr_ack))
		else protocol_break("wr_req rose while wr_ack was still high");

	rd_hold: assert property (@(posedge clock) disable iff (!rstn)
		rd_req |=> !rd_req || $stable(rd_cmd))
		else protocol_break("rd_cmd changed while rd_req was high");

	rsp_answer: assert property (@(posedge clock) disable iff (!rstn)
		$rose(rsp_ack) |-> $past(rsp_req))
		else protocol_break("rsp_ack rose without a read response");

	wr_hold: assert property (@(posedge clock) disable iff (!rstn)
		wr_req |=> !wr_req || $stable(wr_cmd))
		else protocol_break("wr_cmd changed while wr_req was high");

	// a stalled response blocks the next read
	back_pressure: assert property (@(posedge clock) disable iff (!rstn)
		$rose(rd_req) |-> !rsp_req && !rsp_ack)
		else protocol_break("rd_req rose while a read response was still open");

endmodule

`default_nettype wire

// File: project.f
hdl/cu_pkg.sv
hdl/vertex_job_source.sv
hdl/vertex_job_queue.sv
hdl/vertex_write_unit.sv
hdl/cu_control.sv
dv/cu_control_tb.sv

// File: Bender.yml
package:
  name: cu_control

sources:
  - hdl/cu_pkg.sv
  - hdl/vertex_job_source.sv
  - hdl/vertex_job_queue.sv
  - hdl/vertex_write_unit.sv
  - hdl/cu_control.sv
  - target: simulation
    files:
      - dv/cu_control_tb.sv
